/* common/apb_subsys_pkg.sv */
// ###############################################
// APB subsystem shared definitions
// Request, response and APB bus types, the data-lane
// union, the address map and timer register offsets
// ###############################################

package apb_subsys_pkg;

    // Two 32-bit lanes of one 64-bit bus word
    typedef struct packed {
        logic [31:0] hi;                        // Upper word, byte lanes 7..4
        logic [31:0] lo;                        // Lower word, byte lanes 3..0
    } lane_pair_t;

    // The bridge works lane by lane, the requester sees a plain dword
    typedef union packed {
        logic [63:0] dword;
        lane_pair_t  lanes;
    } data_lanes_t;

    // Single transfer request from the requester
    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
        logic [7:0]  size;                      // Bytes: 1, 2, 4 or 8
        logic        write;
        data_lanes_t wdata;
        logic [7:0]  wstrb;
        logic        last;                      // Low marks a burst beat
    } bus_req_t;

    // One-cycle response pulse back to the requester
    typedef struct packed {
        logic        valid;
        logic        err;
        data_lanes_t rdata;
    } bus_resp_t;

    // Bridge to peripheral
    typedef struct packed {
        logic [31:0] paddr;
        logic        pwrite;
        logic [31:0] pwdata;
        logic [3:0]  pstrb;
        logic        psel;
        logic        penable;
    } apb_req_t;

    // Peripheral to bridge
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_resp_t;

    // Address map, every slave owns one window
    localparam logic [31:0] SLV_RAM_BASE = 32'h0000_0000;
    localparam logic [31:0] SLV_TMR_BASE = 32'h0000_1000;
    localparam logic [31:0] SLV_WINDOW   = 32'h0000_1000;

    // Default slave answers at once with an error and all-ones data
    localparam apb_resp_t APB_RESP_DEFAULT = '{
        prdata:  32'hffff_ffff,
        pready:  1'b1,
        pslverr: 1'b1
    };

    // Timer register offsets
    localparam logic [11:0] TMR_CTRL   = 12'h000;
    localparam logic [11:0] TMR_COUNT  = 12'h004;
    localparam logic [11:0] TMR_CMP    = 12'h008;
    localparam logic [11:0] TMR_STATUS = 12'h00c;

    // Timer CTRL bits
    localparam int TMR_CTRL_EN     = 0;        // Counter runs
    localparam int TMR_CTRL_IRQ_EN = 1;        // Match drives the interrupt

    // Merge the strobed bytes of a new word into an old one
    function automatic logic [31:0] apply_strobe(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] res;
        res = old_word;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return res;
    endfunction

endpackage

/* bridge/apb_bridge.sv */
// ###############################################
// Request-to-APB bridge
// Decodes the address map, splits 64-bit accesses
// into two APB transfers, serves unmapped addresses
// with a default error slave and rebuilds the response
// ###############################################

module apb_bridge
    import apb_subsys_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_nrst,
    input  bus_req_t  i_req,
    output logic      o_req_ready,
    output bus_resp_t o_resp,
    output apb_req_t  o_ram_apb,
    input  apb_resp_t i_ram_apb,
    output apb_req_t  o_tmr_apb,
    input  apb_resp_t i_tmr_apb
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_OUT
    } state_t;

    // Slave select codes
    localparam logic [1:0] SEL_RAM = 2'd0;
    localparam logic [1:0] SEL_TMR = 2'd1;
    localparam logic [1:0] SEL_DEF = 2'd2;

    // Control state
    state_t      r_state;
    logic [1:0]  r_sel;
    logic        r_err;
    logic        r_valid;

    // Registered request and read payload
    logic [31:0] r_paddr;
    logic [7:0]  r_size;
    logic        r_write;
    data_lanes_t r_wdata;
    logic [7:0]  r_wstrb;
    data_lanes_t r_rdata;

    logic        accept;
    logic        req_refuse;
    logic [1:0]  req_sel;
    logic        access_done;
    logic        second_half;
    apb_resp_t   sel_resp;
    apb_req_t    apb_out;
    data_lanes_t rdata_next;

    assign o_req_ready = (r_state == ST_IDLE) && !r_valid;   // Low during the pulse
    assign accept      = i_req.valid && o_req_ready;

    // Bursts and 8-byte accesses to the upper word are refused
    assign req_refuse = !i_req.last || ((i_req.size > 8'd4) && i_req.addr[2]);

    always_comb begin
        if ((i_req.addr - SLV_RAM_BASE) < SLV_WINDOW) begin
            req_sel = SEL_RAM;
        end else if ((i_req.addr - SLV_TMR_BASE) < SLV_WINDOW) begin
            req_sel = SEL_TMR;
        end else begin
            req_sel = SEL_DEF;                              // Nothing mapped here
        end
    end

    always_comb begin
        case (r_sel)
            SEL_RAM: sel_resp = i_ram_apb;
            SEL_TMR: sel_resp = i_tmr_apb;
            default: sel_resp = APB_RESP_DEFAULT;
        endcase
    end

    assign access_done = (r_state == ST_ACCESS) && sel_resp.pready;
    // First half of an aligned 8-byte access, the high word follows
    assign second_half = (r_size > 8'd4) && !r_paddr[2];

    // Read data goes into its own lane, a 32-bit read fills both
    always_comb begin
        rdata_next = r_rdata;
        if (r_size <= 8'd4) begin
            rdata_next.lanes.lo = sel_resp.prdata;
            rdata_next.lanes.hi = sel_resp.prdata;
        end else if (!r_paddr[2]) begin
            rdata_next.lanes.lo = sel_resp.prdata;
        end else begin
            rdata_next.lanes.hi = sel_resp.prdata;
        end
    end

    // Shared APB signals, only the selected slave gets psel and penable
    always_comb begin
        apb_out.paddr   = r_paddr;
        apb_out.pwrite  = r_write;
        apb_out.pwdata  = r_paddr[2] ? r_wdata.lanes.hi : r_wdata.lanes.lo;
        apb_out.pstrb   = r_paddr[2] ? r_wstrb[7:4] : r_wstrb[3:0];
        apb_out.psel    = (r_state == ST_SETUP) || (r_state == ST_ACCESS);
        apb_out.penable = (r_state == ST_ACCESS);

        o_ram_apb         = apb_out;
        o_ram_apb.psel    = apb_out.psel && (r_sel == SEL_RAM);
        o_ram_apb.penable = apb_out.penable && (r_sel == SEL_RAM);

        o_tmr_apb         = apb_out;
        o_tmr_apb.psel    = apb_out.psel && (r_sel == SEL_TMR);
        o_tmr_apb.penable = apb_out.penable && (r_sel == SEL_TMR);
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_state <= ST_IDLE;
            r_sel   <= SEL_DEF;
            r_err   <= 1'b0;
            r_valid <= 1'b0;
        end else begin
            r_valid <= 1'b0;
            case (r_state)
                ST_IDLE: begin
                    if (accept) begin
                        r_sel   <= req_sel;
                        r_err   <= req_refuse;
                        r_state <= req_refuse ? ST_OUT : ST_SETUP;
                    end
                end
                ST_SETUP: r_state <= ST_ACCESS;
                ST_ACCESS: begin
                    if (sel_resp.pready) begin
                        r_err   <= r_err | sel_resp.pslverr;   // Either half may fail
                        r_state <= second_half ? ST_SETUP : ST_OUT;
                    end
                end
                ST_OUT: begin
                    r_valid <= 1'b1;
                    r_state <= ST_IDLE;
                end
                default: r_state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            r_paddr <= {i_req.addr[31:2], 2'b00};
            r_size  <= i_req.size;
            r_write <= i_req.write;
            r_wdata <= i_req.wdata;
            r_wstrb <= i_req.wstrb;
            if (req_refuse) begin
                r_rdata.dword <= '1;
            end
        end else if (access_done) begin
            if (second_half) begin
                r_paddr <= r_paddr + 32'd4;                 // Move on to the high word
            end
            r_rdata <= rdata_next;
        end
    end

    assign o_resp.valid = r_valid;
    assign o_resp.err   = r_err;
    assign o_resp.rdata = r_rdata;

endmodule

/* hdl/apb_scratch_ram.sv */
// ###############################################
// APB scratch RAM
// Word memory with byte-strobe writes and
// zero-wait-state reads, window wraps on its size
// ###############################################

module apb_scratch_ram
    import apb_subsys_pkg::*;
#(
    parameter int RAM_WORDS = 16
) (
    input  logic      i_clk,
    input  logic      i_nrst,
    input  apb_req_t  i_apb,
    output apb_resp_t o_apb
);

    localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0]      mem [RAM_WORDS];
    logic [IDX_W-1:0] word_idx;
    logic             wr_en;

    // Byte address to word index, wrapping inside the window
    assign word_idx = IDX_W'(i_apb.paddr[31:2] % RAM_WORDS);

    // Write lands on the access edge
    assign wr_en = i_apb.psel && i_apb.penable && i_apb.pwrite;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int i = 0; i < RAM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[word_idx] <= apply_strobe(mem[word_idx], i_apb.pwdata, i_apb.pstrb);
        end
    end

    // Never stalls and never fails
    assign o_apb.prdata  = mem[word_idx];
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = 1'b0;

endmodule

/* hdl/apb_timer.sv */
// ###############################################
// APB timer
// Free-running counter with a compare register and a
// sticky match flag that drives the interrupt
// ###############################################

module apb_timer
    import apb_subsys_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_nrst,
    input  apb_req_t  i_apb,
    output apb_resp_t o_apb,
    output logic      o_irq
);

    logic [1:0]  r_ctrl;
    logic [31:0] r_count;
    logic [31:0] r_cmp;
    logic        r_match;

    logic [11:0] offset;
    logic        wr_en;
    logic        hit;                               // Offset is a real register
    logic [31:0] rd_word;
    logic [31:0] wr_word;
    logic        match_set;
    logic        match_clr;

    assign offset = i_apb.paddr[11:0];
    assign wr_en  = i_apb.psel && i_apb.penable && i_apb.pwrite && hit;

    always_comb begin
        hit     = 1'b1;
        rd_word = '0;
        case (offset)
            TMR_CTRL:   rd_word = {30'd0, r_ctrl};
            TMR_COUNT:  rd_word = r_count;
            TMR_CMP:    rd_word = r_cmp;
            TMR_STATUS: rd_word = {31'd0, r_match};
            default:    hit = 1'b0;                 // Zero data, slave error
        endcase
    end

    // Strobed bytes replace the current register value
    assign wr_word = apply_strobe(rd_word, i_apb.pwdata, i_apb.pstrb);

    assign match_set = r_ctrl[TMR_CTRL_EN] && (r_count == r_cmp);
    assign match_clr = wr_en && (offset == TMR_STATUS) && wr_word[0];   // Write 1 to clear

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            r_ctrl  <= '0;
            r_count <= '0;
            r_cmp   <= '0;
            r_match <= 1'b0;
            o_irq   <= 1'b0;
        end else begin
            if (wr_en && (offset == TMR_CTRL)) begin
                r_ctrl <= wr_word[1:0];
            end
            if (wr_en && (offset == TMR_CMP)) begin
                r_cmp <= wr_word;
            end
            // A write to COUNT wins over the increment
            if (wr_en && (offset == TMR_COUNT)) begin
                r_count <= wr_word;
            end else if (r_ctrl[TMR_CTRL_EN]) begin
                r_count <= r_count + 32'd1;
            end
            if (match_set) begin
                r_match <= 1'b1;                    // A new match is never lost
            end else if (match_clr) begin
                r_match <= 1'b0;
            end
            o_irq <= r_match && r_ctrl[TMR_CTRL_IRQ_EN];
        end
    end

    assign o_apb.prdata  = rd_word;
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = !hit;

endmodule

/* hdl/apb_subsys_top.sv */
// ###############################################
// APB subsystem top level
// Bridge with a scratch RAM and a timer behind it
// ###############################################

module apb_subsys_top
    import apb_subsys_pkg::*;
#(
    parameter int RAM_WORDS = 16
) (
    input  logic      i_clk,
    input  logic      i_nrst,
    input  bus_req_t  i_req,
    output logic      o_req_ready,
    output bus_resp_t o_resp,
    output logic      o_timer_irq
);

    apb_req_t  ram_req;
    apb_resp_t ram_resp;
    apb_req_t  tmr_req;
    apb_resp_t tmr_resp;

    apb_bridge bridge0 (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req       (i_req),
        .o_req_ready (o_req_ready),
        .o_resp      (o_resp),
        .o_ram_apb   (ram_req),
        .i_ram_apb   (ram_resp),
        .o_tmr_apb   (tmr_req),
        .i_tmr_apb   (tmr_resp)
    );

    apb_scratch_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) ram0 (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_apb  (ram_req),
        .o_apb  (ram_resp)
    );

    apb_timer tmr0 (
        .i_clk  (i_clk),
        .i_nrst (i_nrst),
        .i_apb  (tmr_req),
        .o_apb  (tmr_resp),
        .o_irq  (o_timer_irq)                       // Straight to the top port
    );

endmodule

/* dv/tb_apb_subsys.sv */
// ##################################################
// APB subsystem testbench
// Directed RAM, refusal and timer tests checked
// against a reference memory model
// ##################################################

module tb_apb_subsys
    import apb_subsys_pkg::*;
();

    localparam int REF_WORDS  = 16;
    localparam int READY_WAIT = 16;
    localparam int RESP_WAIT  = 16;
    localparam int IRQ_WAIT   = 100;
    localparam int N_XFERS    = 48;                 // Upper bound on transfers issued
    // Reset, every transfer at the worst turnaround, the irq wait and some slack
    localparam int CYCLE_LIMIT = 16 + N_XFERS * 8 + IRQ_WAIT + 200;

    localparam logic [31:0] CTRL_ADDR   = SLV_TMR_BASE + 32'(TMR_CTRL);
    localparam logic [31:0] COUNT_ADDR  = SLV_TMR_BASE + 32'(TMR_COUNT);
    localparam logic [31:0] CMP_ADDR    = SLV_TMR_BASE + 32'(TMR_CMP);
    localparam logic [31:0] STATUS_ADDR = SLV_TMR_BASE + 32'(TMR_STATUS);
    localparam logic [63:0] ALL_ONES    = 64'hffff_ffff_ffff_ffff;

    logic        i_clk;
    logic        i_nrst;
    bus_req_t    i_req;
    logic        o_req_ready;
    bus_resp_t   o_resp;
    logic        o_timer_irq;

    logic [31:0] ref_mem [REF_WORDS];               // Mirror of the scratch RAM
    logic [31:0] rng_state;
    int          errors;
    int          n_xfers;
    int          cycle_cnt;

    apb_subsys_top #(
        .RAM_WORDS (REF_WORDS)
    ) dut0 (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req       (i_req),
        .o_req_ready (o_req_ready),
        .o_resp      (o_resp),
        .o_timer_irq (o_timer_irq)
    );

    always #4 i_clk = ~i_clk;

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int ref_index(input logic [31:0] addr);
        return int'(addr[31:2] % REF_WORDS);       // RAM window wraps on its size
    endfunction

    function automatic logic [31:0] merge_bytes(
        input logic [31:0] old_word,
        input logic [31:0] new_word,
        input logic [3:0]  strb
    );
        logic [31:0] mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    function automatic void model_write(
        input logic [31:0] addr,
        input logic [7:0]  size,
        input logic [63:0] wdata,
        input logic [7:0]  wstrb
    );
        int lo_idx;
        int hi_idx;
        lo_idx = ref_index(addr);
        hi_idx = ref_index(addr + 32'd4);
        if (size == 8'd8) begin
            ref_mem[lo_idx] = merge_bytes(ref_mem[lo_idx], wdata[31:0], wstrb[3:0]);
            ref_mem[hi_idx] = merge_bytes(ref_mem[hi_idx], wdata[63:32], wstrb[7:4]);
        end else if (addr[2]) begin
            ref_mem[lo_idx] = merge_bytes(ref_mem[lo_idx], wdata[63:32], wstrb[7:4]);
        end else begin
            ref_mem[lo_idx] = merge_bytes(ref_mem[lo_idx], wdata[31:0], wstrb[3:0]);
        end
    endfunction

    // A single word comes back on both lanes
    function automatic logic [63:0] model_read(input logic [31:0] addr, input logic [7:0] size);
        if (size == 8'd8) begin
            return {ref_mem[ref_index(addr + 32'd4)], ref_mem[ref_index(addr)]};
        end
        return {ref_mem[ref_index(addr)], ref_mem[ref_index(addr)]};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("MISMATCH time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
        errors++;
    endtask

    // Starts on a rising edge and returns on the edge where the response is seen
    task automatic send_request(
        input  logic [31:0] addr,
        input  logic [7:0]  size,
        input  logic        write,
        input  logic [63:0] wdata,
        input  logic [7:0]  wstrb,
        input  logic        last,
        output logic        got_err,
        output logic [63:0] got_rdata,
        output int          got_lat,
        output logic        ok
    );
        bus_req_t req;
        int       waited;
        logic     done;
        req             = '0;
        req.valid       = 1'b1;
        req.addr        = addr;
        req.size        = size;
        req.write       = write;
        req.wdata.dword = wdata;
        req.wstrb       = wstrb;
        req.last        = last;
        ok        = 1'b0;
        got_err   = 1'b0;
        got_rdata = '0;
        got_lat   = 0;
        n_xfers++;
        i_req <= req;
        waited = 0;
        done   = 1'b0;
        while (!done && waited < READY_WAIT) begin
            @(posedge i_clk);
            waited++;
            done = o_req_ready;                     // Accepted on this edge
        end
        i_req <= '0;
        if (!done) begin
            $display("Request to %h was never accepted, ready stayed low", addr);
            errors++;
            return;
        end
        waited = 0;
        done   = 1'b0;
        while (!done && waited < RESP_WAIT) begin
            @(posedge i_clk);
            waited++;
            if (o_resp.valid) begin
                done      = 1'b1;
                got_err   = o_resp.err;
                got_rdata = o_resp.rdata.dword;
            end
        end
        if (!done) begin
            $display("No response to the request at %h within %0d cycles", addr, RESP_WAIT);
            errors++;
            return;
        end
        got_lat = waited - 1;                       // Pulse is seen one edge after it rises
        ok      = 1'b1;
    endtask

    task automatic do_write(
        input logic [31:0] addr,
        input logic [7:0]  size,
        input logic [63:0] wdata,
        input logic [7:0]  wstrb,
        input logic        last,
        input logic        exp_err,
        input int          exp_lat
    );
        logic        got_err;
        logic [63:0] got_rdata;
        int          got_lat;
        logic        ok;
        send_request(addr, size, 1'b1, wdata, wstrb, last, got_err, got_rdata, got_lat, ok);
        if (ok && got_err !== exp_err) report_mismatch("o_resp.err", 64'(exp_err), 64'(got_err));
        if (ok && got_lat != exp_lat) report_mismatch("latency", 64'(exp_lat), 64'(got_lat));
        if (ok && exp_err && got_rdata !== ALL_ONES) begin
            report_mismatch("o_resp.rdata", ALL_ONES, got_rdata);
        end
        if (!exp_err && addr < SLV_WINDOW) begin
            model_write(addr, size, wdata, wstrb);
        end
    endtask

    task automatic do_read(
        input logic [31:0] addr,
        input logic [7:0]  size,
        input logic        last,
        input logic        exp_err,
        input logic [63:0] exp_rdata,
        input int          exp_lat
    );
        logic        got_err;
        logic [63:0] got_rdata;
        int          got_lat;
        logic        ok;
        send_request(addr, size, 1'b0, '0, '0, last, got_err, got_rdata, got_lat, ok);
        if (ok && got_err !== exp_err) report_mismatch("o_resp.err", 64'(exp_err), 64'(got_err));
        if (ok && got_lat != exp_lat) report_mismatch("latency", 64'(exp_lat), 64'(got_lat));
        if (ok && got_rdata !== exp_rdata) report_mismatch("o_resp.rdata", exp_rdata, got_rdata);
    endtask

    task automatic test_ram_access();
        logic [31:0] addr;
        logic [31:0] r;
        logic [63:0] data;
        repeat (8) begin                            // Single words on either lane
            addr = (next_rand() % REF_WORDS) * 4;
            data = {next_rand(), next_rand()};
            do_write(addr, 8'd4, data, addr[2] ? 8'hf0 : 8'h0f, 1'b1, 1'b0, 3);
            do_read(addr, 8'd4, 1'b1, 1'b0, model_read(addr, 8'd4), 3);
        end
        repeat (6) begin                            // Aligned dwords with partial strobes
            addr = (next_rand() % 8) * 8;
            r    = next_rand();
            data = {next_rand(), next_rand()};
            do_write(addr, 8'd8, data, r[7:0], 1'b1, 1'b0, 5);
            do_read(addr, 8'd8, 1'b1, 1'b0, model_read(addr, 8'd8), 5);
        end
        data = {next_rand(), next_rand()};
        do_write(32'h40, 8'd4, data, 8'h0f, 1'b1, 1'b0, 3);    // Word 16 lands on word 0
        do_read(32'h0, 8'd4, 1'b1, 1'b0, {data[31:0], data[31:0]}, 3);
    endtask

    task automatic test_refused();
        do_write(32'h8, 8'd8, {next_rand(), next_rand()}, 8'hff, 1'b1, 1'b0, 5);
        do_write(32'h8, 8'd4, {next_rand(), next_rand()}, 8'h0f, 1'b0, 1'b1, 1);
        do_write(32'hc, 8'd8, {next_rand(), next_rand()}, 8'hff, 1'b1, 1'b1, 1);
        do_write(32'h4000, 8'd4, {next_rand(), next_rand()}, 8'h0f, 1'b1, 1'b1, 3);
        do_read(32'h0, 8'd4, 1'b0, 1'b1, ALL_ONES, 1);
        do_read(32'h4000, 8'd4, 1'b1, 1'b1, ALL_ONES, 3);
        do_read(32'h8, 8'd8, 1'b1, 1'b0, model_read(32'h8, 8'd8), 5);
        do_read(32'h0, 8'd4, 1'b1, 1'b0, model_read(32'h0, 8'd4), 3);   // Word 0 kept its value
    endtask

    task automatic test_timer();
        int waited;
        do_write(CMP_ADDR, 8'd4, 64'd20, 8'h0f, 1'b1, 1'b0, 3);
        do_write(COUNT_ADDR, 8'd4, 64'd0, 8'hf0, 1'b1, 1'b0, 3);
        do_write(CTRL_ADDR, 8'd4, 64'd3, 8'h0f, 1'b1, 1'b0, 3);
        waited = 0;
        while (!o_timer_irq && waited < IRQ_WAIT) begin
            @(posedge i_clk);
            waited++;
        end
        if (!o_timer_irq) begin
            $display("Timer interrupt did not rise within %0d cycles", IRQ_WAIT);
            errors++;
        end
        do_read(STATUS_ADDR, 8'd4, 1'b1, 1'b0, {32'd1, 32'd1}, 3);
        do_write(STATUS_ADDR, 8'd4, {32'd1, 32'd0}, 8'hf0, 1'b1, 1'b0, 3);
        if (o_timer_irq !== 1'b0) report_mismatch("o_timer_irq", 64'd0, 64'(o_timer_irq));
        do_read(STATUS_ADDR, 8'd4, 1'b1, 1'b0, 64'd0, 3);
        do_read(SLV_TMR_BASE + 32'h10, 8'd4, 1'b1, 1'b1, 64'd0, 3);   // No register here
    endtask

    initial begin
        i_clk     = 1'b0;
        i_nrst    = 1'b0;
        i_req     = '0;
        rng_state = 32'hf2aaa1db;
        errors    = 0;
        n_xfers   = 0;
        cycle_cnt = 0;
        for (int i = 0; i < REF_WORDS; i++) begin
            ref_mem[i] = '0;
        end
        repeat (16) @(posedge i_clk);
        if (o_req_ready !== 1'b1) report_mismatch("o_req_ready", 64'd1, 64'(o_req_ready));
        if (o_resp.valid !== 1'b0) report_mismatch("o_resp.valid", 64'd0, 64'(o_resp.valid));
        if (o_timer_irq !== 1'b0) report_mismatch("o_timer_irq", 64'd0, 64'(o_timer_irq));
        i_nrst <= 1'b1;
        @(posedge i_clk);
        test_ram_access();
        test_refused();
        test_timer();
        $display("Transfers: %0d  Errors: %0d", n_xfers, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* apb_subsys_top.f */
common/apb_subsys_pkg.sv
bridge/apb_bridge.sv
hdl/apb_scratch_ram.sv
hdl/apb_timer.sv
hdl/apb_subsys_top.sv
dv/tb_apb_subsys.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tb_apb_subsys
FILELIST  := apb_subsys_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
